//--- verilog/mbus_pkg.sv
// Address constants are 23-bit word addresses (byte address bits 23..1); ROM size is a port, not a constant here
package mbus_pkg;

	// ------------------------------
	// Bus widths
	// ------------------------------
	localparam int MBUS_AW = 23;
	localparam int ZBUS_AW = 15;
	localparam int ZRAM_AW = 13;
	localparam int WRAM_AW = 15;

	// ------------------------------
	// Main-bus address map
	// ------------------------------
	// End of cartridge space, byte A00000
	localparam logic [MBUS_AW-1:0] ROM_TOP     = 23'h500000;
	// Sub-bus window A00000-A0FFFF, matched on bits 22..15
	localparam logic [MBUS_AW-1:0] ZBUS_BASE   = 23'h500000;
	// Z80 bus request, byte A11100
	localparam logic [MBUS_AW-1:0] CTRL_BUSREQ = 23'h508880;
	// Z80 reset, byte A11200
	localparam logic [MBUS_AW-1:0] CTRL_RESET  = 23'h508900;
	// Work RAM E00000-FFFFFF, matched on bits 22..20
	localparam logic [MBUS_AW-1:0] WRAM_BASE   = 23'h700000;

	// Open-bus value after reset (68000 NOP)
	localparam logic [15:0] NO_DATA_RESET = 16'h4E71;

	// ------------------------------
	// Enums
	// ------------------------------
	typedef enum logic [1:0] {
		SRC_NONE,
		SRC_M68K,
		SRC_Z80,
		SRC_DMA
	} mbus_src_t;

	typedef enum logic [2:0] {
		IDLE,
		SELECT,
		RAM_READ,
		ROM_READ,
		ZBUS_PRE,
		ZBUS_READ,
		FINISH
	} mbus_state_t;

	typedef enum logic [1:0] {
		Z_IDLE,
		Z_READ,
		Z_FINISH
	} zbus_state_t;

endpackage

//--- verilog/work_ram.sv
// No reset and no clearing; contents are undefined until written; read data is the value before a same-cycle write
`timescale 1ns/1ps

module work_ram (
	input  logic                         MCLK,
	input  logic [mbus_pkg::WRAM_AW-1:0] wram_addr,
	input  logic [15:0]                  wram_wdata,
	input  logic                         wram_we_u,
	input  logic                         wram_we_l,
	output logic [15:0]                  wram_q
);
	import mbus_pkg::*;

	// One array per byte lane
	logic [7:0] mem_u [0:2**WRAM_AW-1];
	logic [7:0] mem_l [0:2**WRAM_AW-1];

	always_ff @(posedge MCLK) begin
		if (wram_we_u)
			mem_u[wram_addr] <= wram_wdata[15:8];
		if (wram_we_l)
			mem_l[wram_addr] <= wram_wdata[7:0];
		wram_q <= {mem_u[wram_addr], mem_l[wram_addr]};
	end

endmodule

//--- verilog/zbus_ctrl.sv
// Z80 local accesses are served at 0000-7FFF only; reads outside Z80 RAM return FF; no FM or VDP on this bus
`timescale 1ns/1ps

module zbus_ctrl (
	input  logic                         MCLK,
	input  logic                         reset,
	input  logic                         zsel,
	input  logic [mbus_pkg::ZBUS_AW-1:0] zaddr,
	input  logic [15:0]                  zwdata,
	input  logic                         zrnw,
	input  logic                         zuds_n,
	input  logic                         ctrl_we,
	output logic                         zdtack_n,
	output logic [7:0]                   zrdata,
	output logic                         ctrl_q,
	output logic [8:0]                   z80_bank,
	input  logic [15:0]                  z80_addr,
	input  logic [7:0]                   z80_dout,
	input  logic                         z80_mreq_n,
	input  logic                         z80_rd_n,
	input  logic                         z80_wr_n,
	output logic [7:0]                   z80_local_din,
	output logic                         z80_local_dtack_n,
	output logic                         z80_reset_n,
	output logic                         z80_busreq_n
);
	import mbus_pkg::*;

	zbus_state_t              zstate;
	logic                     from_mbus;
	logic [ZBUS_AW-1:0]       za;
	logic [7:0]               zdo;
	logic                     zwe;
	logic [7:0]               zram [0:2**ZRAM_AW-1];
	logic [7:0]               zram_q;
	logic                     zram_sel;
	logic                     bus_free;
	logic                     z80_local_sel;
	logic [7:0]               zbus_di;

	// ------------------------------
	// Control registers
	// ------------------------------
	// Byte address bit 8 tells A11100 from A11200
	assign ctrl_q   = zaddr[8] ? z80_busreq_n : z80_reset_n;
	assign bus_free = ~z80_busreq_n & z80_reset_n;

	always_ff @(posedge MCLK) begin
		if (reset) begin
			z80_busreq_n <= 1'b1;
			z80_reset_n  <= 1'b0;
		end else if (ctrl_we) begin
			if (zaddr[8])
				z80_busreq_n <= ~zwdata[8];
			else
				z80_reset_n <= zwdata[8];
		end
	end

	// ------------------------------
	// Z80 RAM and bank register
	// ------------------------------
	assign zram_sel = (za[14:13] == 2'b00);
	assign zbus_di  = zram_sel ? zram_q : 8'hFF;

	always_ff @(posedge MCLK) begin
		if (zwe && zram_sel)
			zram[za[ZRAM_AW-1:0]] <= zdo;
		zram_q <= zram[za[ZRAM_AW-1:0]];
	end

	// Serial load with bit 0 entering at the top
	always_ff @(posedge MCLK) begin
		if (reset)
			z80_bank <= 9'd0;
		else if (zwe && za[14:8] == 7'h60)
			z80_bank <= {zdo[0], z80_bank[8:1]};
	end

	// ------------------------------
	// Sub-bus FSM
	// ------------------------------
	assign z80_local_sel = ~z80_mreq_n & (~z80_rd_n | ~z80_wr_n) & ~z80_addr[15];

	always_ff @(posedge MCLK) begin
		zwe <= 1'b0;
		if (reset) begin
			zstate            <= Z_IDLE;
			zdtack_n          <= 1'b1;
			z80_local_dtack_n <= 1'b1;
		end else begin
			if (~zsel)
				zdtack_n <= 1'b1;
			if (~z80_local_sel)
				z80_local_dtack_n <= 1'b1;

			case (zstate)
				Z_IDLE:
					// Main bus first
					if (zsel && zdtack_n) begin
						za        <= zaddr;
						zdo       <= zuds_n ? zwdata[7:0] : zwdata[15:8];
						zwe       <= ~zrnw & bus_free;
						from_mbus <= 1'b1;
						zstate    <= Z_READ;
					end else if (z80_local_sel && z80_local_dtack_n) begin
						za        <= z80_addr[ZBUS_AW-1:0];
						zdo       <= z80_dout;
						zwe       <= ~z80_wr_n;
						from_mbus <= 1'b0;
						zstate    <= Z_READ;
					end

				Z_READ:
					zstate <= Z_FINISH;

				Z_FINISH: begin
					if (from_mbus) begin
						zrdata   <= bus_free ? zbus_di : 8'hFF;
						zdtack_n <= 1'b0;
					end else begin
						z80_local_din     <= zbus_di;
						z80_local_dtack_n <= 1'b0;
					end
					zstate <= Z_IDLE;
				end

				default:
					zstate <= Z_IDLE;
			endcase
		end
	end

	// No main-bus write reaches Z80 RAM while the Z80 bus is not free
	assert property (@(posedge MCLK) disable iff (reset)
		(zwe && from_mbus && zram_sel) |-> bus_free);

endmodule

//--- verilog/mbus_ctrl.sv
// rom_size counts 16-bit words; a ROM that never acknowledges stalls the main bus for good
`timescale 1ns/1ps

module mbus_ctrl (
	input  logic                         MCLK,
	input  logic                         reset,
	input  logic [mbus_pkg::MBUS_AW-1:0] rom_size,
	input  logic                         grant_valid,
	input  mbus_pkg::mbus_src_t          grant_src,
	input  logic [mbus_pkg::MBUS_AW-1:0] grant_addr,
	input  logic [15:0]                  grant_wdata,
	input  logic                         grant_rnw,
	input  logic                         grant_uds_n,
	input  logic                         grant_lds_n,
	output logic                         done,
	output logic [15:0]                  rdata,
	output logic [mbus_pkg::MBUS_AW-1:0] rom_addr,
	output logic                         rom_req,
	input  logic                         rom_ack,
	input  logic [15:0]                  rom_data,
	output logic [mbus_pkg::WRAM_AW-1:0] wram_addr,
	output logic [15:0]                  wram_wdata,
	output logic                         wram_we_u,
	output logic                         wram_we_l,
	input  logic [15:0]                  wram_q,
	output logic                         zsel,
	output logic [mbus_pkg::ZBUS_AW-1:0] zaddr,
	output logic [15:0]                  zwdata,
	output logic                         zrnw,
	output logic                         zuds_n,
	output logic                         ctrl_we,
	input  logic                         zdtack_n,
	input  logic [7:0]                   zrdata,
	input  logic                         ctrl_q
);
	import mbus_pkg::*;

	mbus_state_t state;
	logic [15:0] no_data;
	logic        m68k_read;

	// Grant fields stay stable for the whole access
	assign wram_addr  = grant_addr[WRAM_AW-1:0];
	assign wram_wdata = grant_wdata;
	assign zaddr      = {grant_addr[ZBUS_AW-2:0], zuds_n};
	assign zwdata     = grant_wdata;
	assign zrnw       = grant_rnw;

	// Only 68000 reads refresh the open-bus value
	assign m68k_read = (grant_src == SRC_M68K) & grant_rnw;

	always_ff @(posedge MCLK) begin
		done      <= 1'b0;
		wram_we_u <= 1'b0;
		wram_we_l <= 1'b0;
		ctrl_we   <= 1'b0;
		if (reset) begin
			state   <= IDLE;
			rom_req <= 1'b0;
			zsel    <= 1'b0;
			zuds_n  <= 1'b1;
			no_data <= NO_DATA_RESET;
		end else begin
			case (state)
				IDLE:
					if (grant_valid)
						state <= SELECT;

				// ------------------------------
				// Address decode
				// ------------------------------
				SELECT:
					if (grant_addr < ROM_TOP) begin
						if (grant_addr < rom_size) begin
							rom_addr <= grant_addr;
							rom_req  <= ~rom_ack;
							state    <= ROM_READ;
						end else begin
							// Past the end of the cartridge
							rdata <= 16'h0000;
							done  <= 1'b1;
							state <= FINISH;
						end
					end else if (grant_addr[MBUS_AW-1:15] == ZBUS_BASE[MBUS_AW-1:15]) begin
						state <= ZBUS_PRE;
					end else if (grant_addr == CTRL_BUSREQ || grant_addr == CTRL_RESET) begin
						rdata   <= {no_data[15:9], ctrl_q, no_data[7:0]};
						ctrl_we <= ~grant_rnw & ~grant_uds_n;
						done    <= 1'b1;
						state   <= FINISH;
					end else if (grant_addr[MBUS_AW-1:20] == WRAM_BASE[MBUS_AW-1:20]) begin
						wram_we_u <= ~grant_rnw & ~grant_uds_n;
						wram_we_l <= ~grant_rnw & ~grant_lds_n;
						state     <= RAM_READ;
					end else begin
						rdata <= no_data;
						done  <= 1'b1;
						state <= FINISH;
					end

				RAM_READ: begin
					rdata <= wram_q;
					if (m68k_read)
						no_data <= wram_q;
					done  <= 1'b1;
					state <= FINISH;
				end

				ROM_READ:
					if (rom_req == rom_ack) begin
						rdata <= rom_data;
						if (m68k_read)
							no_data <= rom_data;
						done  <= 1'b1;
						state <= FINISH;
					end

				// ------------------------------
				// Z80 sub-bus
				// ------------------------------
				ZBUS_PRE: begin
					// Lane strobe of the granted master
					zuds_n <= grant_uds_n;
					zsel   <= 1'b1;
					state  <= ZBUS_READ;
				end

				ZBUS_READ:
					if (~zdtack_n) begin
						zsel  <= 1'b0;
						rdata <= {zrdata, zrdata};
						done  <= 1'b1;
						state <= FINISH;
					end

				FINISH:
					// 68000 write waits for its strobe release
					if (!(grant_valid && grant_src == SRC_M68K && !grant_rnw))
						state <= IDLE;

				default:
					state <= IDLE;
			endcase
		end
	end

	// A fresh ROM request is raised only when the ROM read starts
	assert property (@(posedge MCLK) disable iff (reset)
		$changed(rom_req) |-> state == ROM_READ && $past(state) == SELECT);

	// Write strobes follow the granted direction
	assert property (@(posedge MCLK) disable iff (reset)
		(wram_we_u || wram_we_l || ctrl_we) |-> !grant_rnw);

endmodule

//--- verilog/master_select.sv
// Z80 reaches the main bus only at 8000-FFFF; 68000 byte strobes must be valid together with as_n
`timescale 1ns/1ps

module master_select (
	input  logic                         MCLK,
	input  logic                         reset,
	input  logic                         m68k_as_n,
	input  logic                         m68k_uds_n,
	input  logic                         m68k_lds_n,
	input  logic                         m68k_rnw,
	input  logic [mbus_pkg::MBUS_AW-1:0] m68k_addr,
	input  logic [15:0]                  m68k_dout,
	output logic [15:0]                  m68k_din,
	output logic                         m68k_dtack_n,
	input  logic                         z80_mreq_n,
	input  logic                         z80_rd_n,
	input  logic                         z80_wr_n,
	input  logic [15:0]                  z80_addr,
	input  logic [7:0]                   z80_dout,
	output logic [7:0]                   z80_mbus_din,
	output logic                         z80_mbus_dtack_n,
	input  logic                         dma_sel,
	input  logic [mbus_pkg::MBUS_AW-1:0] dma_addr,
	output logic [15:0]                  dma_din,
	output logic                         dma_dtack_n,
	input  logic [8:0]                   z80_bank,
	input  logic                         done,
	input  logic [15:0]                  rdata,
	output logic                         grant_valid,
	output mbus_pkg::mbus_src_t          grant_src,
	output logic [mbus_pkg::MBUS_AW-1:0] grant_addr,
	output logic [15:0]                  grant_wdata,
	output logic                         grant_rnw,
	output logic                         grant_uds_n,
	output logic                         grant_lds_n
);
	import mbus_pkg::*;

	logic m68k_req;
	logic z80_req;
	logic dma_req;
	logic m68k_wr_hold;

	// A master is pending while its strobe is active and its last answer was taken
	assign m68k_req = ~m68k_as_n & m68k_dtack_n;
	assign z80_req  = ~z80_mreq_n & (~z80_rd_n | ~z80_wr_n) & z80_addr[15] & z80_mbus_dtack_n;
	assign dma_req  = dma_sel & dma_dtack_n;

	// Answered 68000 write keeps the bus until as_n goes high
	assign m68k_wr_hold = grant_valid & (grant_src == SRC_M68K) & ~grant_rnw & ~m68k_dtack_n;

	always_ff @(posedge MCLK) begin
		if (reset) begin
			grant_valid      <= 1'b0;
			grant_src        <= SRC_NONE;
			m68k_dtack_n     <= 1'b1;
			z80_mbus_dtack_n <= 1'b1;
			dma_dtack_n      <= 1'b1;
		end else begin
			// Strobe release ends the answer
			if (m68k_as_n)
				m68k_dtack_n <= 1'b1;
			if (z80_mreq_n | (z80_rd_n & z80_wr_n))
				z80_mbus_dtack_n <= 1'b1;
			if (~dma_sel)
				dma_dtack_n <= 1'b1;

			if (done) begin
				if (grant_src != SRC_M68K || grant_rnw) begin
					grant_valid <= 1'b0;
					grant_src   <= SRC_NONE;
				end
				case (grant_src)
					SRC_M68K: begin
						m68k_din     <= rdata;
						m68k_dtack_n <= 1'b0;
					end
					SRC_Z80: begin
						// Even Z80 address takes the upper byte
						z80_mbus_din     <= z80_addr[0] ? rdata[7:0] : rdata[15:8];
						z80_mbus_dtack_n <= 1'b0;
					end
					SRC_DMA: begin
						dma_din     <= rdata;
						dma_dtack_n <= 1'b0;
					end
					default: ;
				endcase
			end else if (m68k_wr_hold & m68k_as_n) begin
				grant_valid <= 1'b0;
				grant_src   <= SRC_NONE;
			end else if (~grant_valid) begin
				// Fixed priority 68000, Z80, DMA
				if (m68k_req) begin
					grant_valid <= 1'b1;
					grant_src   <= SRC_M68K;
					grant_addr  <= m68k_addr;
					grant_wdata <= m68k_dout;
					grant_rnw   <= m68k_rnw;
					grant_uds_n <= m68k_uds_n;
					grant_lds_n <= m68k_lds_n;
				end else if (z80_req) begin
					grant_valid <= 1'b1;
					grant_src   <= SRC_Z80;
					// Bank register supplies bits 23..15 of the byte address
					grant_addr  <= {z80_bank, z80_addr[14:1]};
					grant_wdata <= {z80_dout, z80_dout};
					grant_rnw   <= z80_wr_n;
					grant_uds_n <= z80_addr[0];
					grant_lds_n <= ~z80_addr[0];
				end else if (dma_req) begin
					grant_valid <= 1'b1;
					grant_src   <= SRC_DMA;
					grant_addr  <= dma_addr;
					grant_wdata <= 16'h0000;
					grant_rnw   <= 1'b1;
					grant_uds_n <= 1'b0;
					grant_lds_n <= 1'b0;
				end
			end
		end
	end

	// The processing side answers only an issued grant
	assert property (@(posedge MCLK) disable iff (reset) done |-> grant_valid);

endmodule

//--- verilog/genesis_mbus.sv
// System bus only; no CPU cores or VDP; rom_size counts 16-bit words; all logic runs on every MCLK
`timescale 1ns/1ps

module genesis_mbus (
	input  logic                         MCLK,
	input  logic                         reset,
	input  logic [mbus_pkg::MBUS_AW-1:0] rom_size,
	input  logic                         m68k_as_n,
	input  logic                         m68k_uds_n,
	input  logic                         m68k_lds_n,
	input  logic                         m68k_rnw,
	input  logic [mbus_pkg::MBUS_AW-1:0] m68k_addr,
	input  logic [15:0]                  m68k_dout,
	output logic [15:0]                  m68k_din,
	output logic                         m68k_dtack_n,
	input  logic                         z80_mreq_n,
	input  logic                         z80_rd_n,
	input  logic                         z80_wr_n,
	input  logic [15:0]                  z80_addr,
	input  logic [7:0]                   z80_dout,
	output logic [7:0]                   z80_din,
	output logic                         z80_wait_n,
	input  logic                         dma_sel,
	input  logic [mbus_pkg::MBUS_AW-1:0] dma_addr,
	output logic [15:0]                  dma_din,
	output logic                         dma_dtack_n,
	output logic [mbus_pkg::MBUS_AW-1:0] rom_addr,
	output logic                         rom_req,
	input  logic                         rom_ack,
	input  logic [15:0]                  rom_data,
	output logic                         z80_reset_n,
	output logic                         z80_busreq_n
);
	import mbus_pkg::*;

	logic               grant_valid;
	mbus_src_t          grant_src;
	logic [MBUS_AW-1:0] grant_addr;
	logic [15:0]        grant_wdata;
	logic               grant_rnw;
	logic               grant_uds_n;
	logic               grant_lds_n;
	logic               done;
	logic [15:0]        rdata;
	logic [7:0]         z80_mbus_din;
	logic               z80_mbus_dtack_n;
	logic [8:0]         z80_bank;
	logic [WRAM_AW-1:0] wram_addr;
	logic [15:0]        wram_wdata;
	logic               wram_we_u;
	logic               wram_we_l;
	logic [15:0]        wram_q;
	logic               zsel;
	logic [ZBUS_AW-1:0] zaddr;
	logic [15:0]        zwdata;
	logic               zrnw;
	logic               zuds_n;
	logic               ctrl_we;
	logic               zdtack_n;
	logic [7:0]         zrdata;
	logic               ctrl_q;
	logic [7:0]         z80_local_din;
	logic               z80_local_dtack_n;

	// Either answer releases the Z80; no access means no wait
	assign z80_wait_n = z80_mreq_n | (z80_rd_n & z80_wr_n) | ~z80_mbus_dtack_n |
		~z80_local_dtack_n;
	assign z80_din = ~z80_local_dtack_n ? z80_local_din : z80_mbus_din;

	master_select u_master_select (
		.MCLK, .reset,
		.m68k_as_n, .m68k_uds_n, .m68k_lds_n, .m68k_rnw, .m68k_addr, .m68k_dout,
		.m68k_din, .m68k_dtack_n,
		.z80_mreq_n, .z80_rd_n, .z80_wr_n, .z80_addr, .z80_dout,
		.z80_mbus_din, .z80_mbus_dtack_n,
		.dma_sel, .dma_addr, .dma_din, .dma_dtack_n,
		.z80_bank, .done, .rdata,
		.grant_valid, .grant_src, .grant_addr, .grant_wdata, .grant_rnw,
		.grant_uds_n, .grant_lds_n
	);

	mbus_ctrl u_mbus_ctrl (
		.MCLK, .reset, .rom_size,
		.grant_valid, .grant_src, .grant_addr, .grant_wdata, .grant_rnw,
		.grant_uds_n, .grant_lds_n,
		.done, .rdata,
		.rom_addr, .rom_req, .rom_ack, .rom_data,
		.wram_addr, .wram_wdata, .wram_we_u, .wram_we_l, .wram_q,
		.zsel, .zaddr, .zwdata, .zrnw, .zuds_n, .ctrl_we,
		.zdtack_n, .zrdata, .ctrl_q
	);

	work_ram u_work_ram (
		.MCLK, .wram_addr, .wram_wdata, .wram_we_u, .wram_we_l, .wram_q
	);

	zbus_ctrl u_zbus_ctrl (
		.MCLK, .reset,
		.zsel, .zaddr, .zwdata, .zrnw, .zuds_n, .ctrl_we,
		.zdtack_n, .zrdata, .ctrl_q, .z80_bank,
		.z80_addr, .z80_dout, .z80_mreq_n, .z80_rd_n, .z80_wr_n,
		.z80_local_din, .z80_local_dtack_n,
		.z80_reset_n, .z80_busreq_n
	);

endmodule

//--- testbench/tb_model.svh
// Reference model and bus tasks; work RAM and Z80 RAM are only read back where written
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [15:0] ref_wram [0:32767];
logic [7:0]  ref_zram [0:8191];
logic [15:0] ref_open;
logic        ref_busreq_n;
logic        ref_reset_n;
logic [8:0]  ref_bank;

// Cartridge contents, every address bit takes part
function automatic logic [15:0] rom_word(input logic [22:0] a);
	return a[15:0] ^ {a[22:16], a[22:14]} ^ 16'h5A3C;
endfunction

// Sub-bus byte as seen from the main bus
function automatic logic [7:0] zbus_byte(input logic [14:0] zb);
	if (ref_busreq_n || !ref_reset_n)
		return 8'hFF;
	if (zb[14:13] == 2'b00)
		return ref_zram[zb[12:0]];
	return 8'hFF;
endfunction

// Expected main-bus read data; lane picks the sub-bus byte
function automatic logic [15:0] ref_read(input logic [22:0] a, input logic lane);
	logic [7:0] b;
	if (a < ROM_TOP) begin
		return (a < ROM_SIZE) ? rom_word(a) : 16'h0000;
	end else if (a[22:15] == ZBUS_BASE[22:15]) begin
		b = zbus_byte({a[13:0], lane});
		return {b, b};
	end else if (a == CTRL_BUSREQ) begin
		return {ref_open[15:9], ref_busreq_n, ref_open[7:0]};
	end else if (a == CTRL_RESET) begin
		return {ref_open[15:9], ref_reset_n, ref_open[7:0]};
	end else if (a[22:20] == 3'b111) begin
		return ref_wram[a[14:0]];
	end
	return ref_open;
endfunction

// Expected Z80 read data, local or through the bank window
function automatic logic [7:0] z80_ref_read(input logic [15:0] a);
	logic [15:0] w;
	if (a[15]) begin
		w = ref_read({ref_bank, a[14:1]}, a[0]);
		return a[0] ? w[7:0] : w[15:8];
	end
	return (a[14:13] == 2'b00) ? ref_zram[a[12:0]] : 8'hFF;
endfunction

function automatic void model_m68k_write(input logic [22:0] a, input logic [15:0] d,
	input logic uds_n, input logic lds_n);
	logic [14:0] zb;
	zb = {a[13:0], uds_n};
	if (a[22:20] == 3'b111) begin
		if (!uds_n)
			ref_wram[a[14:0]][15:8] = d[15:8];
		if (!lds_n)
			ref_wram[a[14:0]][7:0] = d[7:0];
	end else if (a[22:15] == ZBUS_BASE[22:15]) begin
		// Dropped unless the Z80 bus is granted
		if (!ref_busreq_n && ref_reset_n && zb[14:13] == 2'b00)
			ref_zram[zb[12:0]] = uds_n ? d[7:0] : d[15:8];
	end else if (a == CTRL_BUSREQ && !uds_n) begin
		ref_busreq_n = ~d[8];
	end else if (a == CTRL_RESET && !uds_n) begin
		ref_reset_n = d[8];
	end
endfunction

function automatic void model_z80_write(input logic [15:0] a, input logic [7:0] d);
	logic [22:0] w;
	w = {ref_bank, a[14:1]};
	if (a[15]) begin
		if (w[22:20] == 3'b111) begin
			if (a[0])
				ref_wram[w[14:0]][7:0] = d;
			else
				ref_wram[w[14:0]][15:8] = d;
		end
	end else begin
		if (a[14:13] == 2'b00)
			ref_zram[a[12:0]] = d;
		if (a[14:8] == 7'h60)
			ref_bank = {d[0], ref_bank[8:1]};
	end
endfunction

task automatic m68k_write(input logic [22:0] a, input logic [15:0] d,
	input logic uds_n, input logic lds_n);
	@(negedge MCLK);
	m68k_addr  = a;
	m68k_dout  = d;
	m68k_rnw   = 1'b0;
	m68k_uds_n = uds_n;
	m68k_lds_n = lds_n;
	m68k_as_n  = 1'b0;
	@(negedge MCLK);
	while (m68k_dtack_n)
		@(negedge MCLK);
	m68k_as_n  = 1'b1;
	m68k_uds_n = 1'b1;
	m68k_lds_n = 1'b1;
	m68k_rnw   = 1'b1;
	@(negedge MCLK);
	while (!m68k_dtack_n)
		@(negedge MCLK);
	model_m68k_write(a, d, uds_n, lds_n);
endtask

task automatic m68k_read(input logic [22:0] a, input logic uds_n, input logic lds_n);
	logic [15:0] want;
	@(negedge MCLK);
	m68k_addr  = a;
	m68k_rnw   = 1'b1;
	m68k_uds_n = uds_n;
	m68k_lds_n = lds_n;
	m68k_as_n  = 1'b0;
	@(negedge MCLK);
	while (m68k_dtack_n)
		@(negedge MCLK);
	want = ref_read(a, uds_n);
	expect_value("m68k_din", m68k_din, want);
	// ROM inside the cartridge and work RAM refresh the open-bus value
	if ((a < ROM_TOP && a < ROM_SIZE) || a[22:20] == 3'b111)
		ref_open = want;
	m68k_as_n  = 1'b1;
	m68k_uds_n = 1'b1;
	m68k_lds_n = 1'b1;
	@(negedge MCLK);
	while (!m68k_dtack_n)
		@(negedge MCLK);
endtask

task automatic z80_access(input logic [15:0] a, input logic [7:0] d, input logic wr);
	@(negedge MCLK);
	z80_addr   = a;
	z80_dout   = d;
	z80_mreq_n = 1'b0;
	z80_rd_n   = wr;
	z80_wr_n   = ~wr;
	@(negedge MCLK);
	while (!z80_wait_n)
		@(negedge MCLK);
	if (wr)
		model_z80_write(a, d);
	else
		expect_value("z80_din", {8'h00, z80_din}, {8'h00, z80_ref_read(a)});
	z80_mreq_n = 1'b1;
	z80_rd_n   = 1'b1;
	z80_wr_n   = 1'b1;
	// Answer clears on the next rising edge
	@(negedge MCLK);
endtask

task automatic dma_read(input logic [22:0] a);
	@(negedge MCLK);
	dma_addr = a;
	dma_sel  = 1'b1;
	@(negedge MCLK);
	while (dma_dtack_n)
		@(negedge MCLK);
	expect_value("dma_din", dma_din, ref_read(a, 1'b0));
	dma_sel = 1'b0;
	@(negedge MCLK);
	while (!dma_dtack_n)
		@(negedge MCLK);
endtask

`endif

//--- testbench/tb_genesis_mbus.sv
// Testbench for genesis_mbus; ROM size fixed at 40000 words, responder answers in 1 to 4 cycles
`timescale 1ns/1ps

module tb_genesis_mbus;
	import mbus_pkg::*;

	localparam logic [22:0] ROM_SIZE = 23'h040000;
	localparam int ACCESS_COUNT = 120;
	localparam int WATCHDOG_CYCLES = 200 * ACCESS_COUNT + 1000;

	logic        MCLK;
	logic        reset;
	logic [22:0] rom_size;
	logic        m68k_as_n, m68k_uds_n, m68k_lds_n, m68k_rnw;
	logic [22:0] m68k_addr;
	logic [15:0] m68k_dout, m68k_din;
	logic        m68k_dtack_n;
	logic        z80_mreq_n, z80_rd_n, z80_wr_n;
	logic [15:0] z80_addr;
	logic [7:0]  z80_dout, z80_din;
	logic        z80_wait_n;
	logic        dma_sel;
	logic [22:0] dma_addr;
	logic [15:0] dma_din;
	logic        dma_dtack_n;
	logic [22:0] rom_addr;
	logic        rom_req, rom_ack;
	logic [15:0] rom_data;
	logic        z80_reset_n, z80_busreq_n;

	// Pending comparisons, filled by the bus tasks
	string       q_name [$];
	logic [15:0] q_got [$];
	logic [15:0] q_want [$];
	int          value_errors = 0;
	int          flow_errors = 0;
	int          seed = 20;
	int          data_seed = 20;

	function automatic void expect_value(input string name, input logic [15:0] got,
		input logic [15:0] want);
		q_name.push_back(name);
		q_got.push_back(got);
		q_want.push_back(want);
	endfunction

	`include "tb_model.svh"

	genesis_mbus uut (.*);

	always #10 MCLK = ~MCLK;

	// ------------------------------
	// Compare process
	// ------------------------------
	always @(posedge MCLK) begin
		while (q_got.size() > 0) begin
			assert (q_got[0] === q_want[0]) else begin
				$display("CHECK FAILED %s got %h expected %h", q_name[0], q_got[0], q_want[0]);
				value_errors++;
			end
			void'(q_name.pop_front());
			void'(q_got.pop_front());
			void'(q_want.pop_front());
		end
	end

	// ROM responder, toggle handshake
	initial begin
		int delay;
		rom_ack  = 1'b0;
		rom_data = 16'h0000;
		forever begin
			@(negedge MCLK);
			if (!reset && rom_req !== rom_ack) begin
				delay = 1 + int'($unsigned($random(seed)) % 4);
				repeat (delay - 1) @(negedge MCLK);
				rom_data = rom_word(rom_addr);
				rom_ack  = rom_req;
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge MCLK);
		$display("Timeout: the bus did not answer within %0d cycles", WATCHDOG_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

	// ------------------------------
	// Stimulus
	// ------------------------------
	initial begin
		logic [31:0] rnd;
		logic [22:0] wr_addr [0:7];
		logic [22:0] wa;
		logic [15:0] za;
		logic [8:0]  bank;
		logic        lane;
		time         t_m68k, t_dma;
		MCLK = 1'b0;
		reset = 1'b1;
		rom_size = ROM_SIZE;
		m68k_as_n = 1'b1;
		m68k_uds_n = 1'b1;
		m68k_lds_n = 1'b1;
		m68k_rnw = 1'b1;
		m68k_addr = '0;
		m68k_dout = '0;
		z80_mreq_n = 1'b1;
		z80_rd_n = 1'b1;
		z80_wr_n = 1'b1;
		z80_addr = '0;
		z80_dout = '0;
		dma_sel = 1'b0;
		dma_addr = '0;
		ref_open = NO_DATA_RESET;
		ref_busreq_n = 1'b1;
		ref_reset_n = 1'b0;
		ref_bank = 9'd0;
		repeat (5) @(negedge MCLK);
		reset = 1'b0;

		// Reset values and the open bus
		@(negedge MCLK);
		expect_value("m68k_dtack_n", {15'h0, m68k_dtack_n}, 16'h0001);
		expect_value("dma_dtack_n", {15'h0, dma_dtack_n}, 16'h0001);
		expect_value("z80_wait_n", {15'h0, z80_wait_n}, 16'h0001);
		expect_value("z80_reset_n", {15'h0, z80_reset_n}, 16'h0000);
		expect_value("z80_busreq_n", {15'h0, z80_busreq_n}, 16'h0001);
		m68k_read(23'h600000, 1'b0, 1'b0);

		// Work RAM words then single bytes
		for (int i = 0; i < 8; i++) begin
			rnd = $random(data_seed);
			wr_addr[i] = {3'b111, 5'b00000, rnd[14:0]};
			m68k_write(wr_addr[i], rnd[31:16], 1'b0, 1'b0);
			rnd = $random(data_seed);
			lane = rnd[16];
			m68k_write(wr_addr[i], rnd[15:0], lane, ~lane);
			m68k_read(wr_addr[i], 1'b0, 1'b0);
		end

		// Cartridge in range, past rom_size, then open bus
		for (int i = 0; i < 4; i++) begin
			rnd = $random(data_seed);
			m68k_read({5'b00000, rnd[17:0]}, 1'b0, 1'b0);
		end
		m68k_read(23'h100000, 1'b0, 1'b0);
		m68k_read(23'h600000, 1'b0, 1'b0);
		m68k_read(wr_addr[3], 1'b0, 1'b0);
		m68k_read(23'h600000, 1'b0, 1'b0);

		// Z80 bus held in reset
		z80_access(16'h0010, 8'h3C, 1'b1);
		m68k_read(ZBUS_BASE | 23'h000008, 1'b0, 1'b1);
		m68k_write(ZBUS_BASE | 23'h000008, 16'hC300, 1'b0, 1'b1);
		m68k_write(CTRL_RESET, 16'h0100, 1'b0, 1'b0);
		m68k_write(CTRL_BUSREQ, 16'h0100, 1'b0, 1'b0);
		m68k_read(CTRL_RESET, 1'b0, 1'b0);
		m68k_read(CTRL_BUSREQ, 1'b0, 1'b0);
		expect_value("z80_reset_n", {15'h0, z80_reset_n}, 16'h0001);
		expect_value("z80_busreq_n", {15'h0, z80_busreq_n}, 16'h0000);
		m68k_read(ZBUS_BASE | 23'h000008, 1'b0, 1'b1);
		for (int j = 0; j < 4; j++) begin
			rnd = $random(data_seed);
			wa = ZBUS_BASE | (23'h000020 + 23'(j));
			m68k_write(wa, {rnd[7:0], 8'h00}, 1'b0, 1'b1);
			m68k_write(wa, {8'h00, rnd[15:8]}, 1'b1, 1'b0);
			m68k_read(wa, 1'b0, 1'b1);
			m68k_read(wa, 1'b1, 1'b0);
			z80_access({1'b0, wa[13:0], 1'b0}, 8'h00, 1'b0);
			z80_access({1'b0, wa[13:0], 1'b1}, 8'h00, 1'b0);
		end

		// Bank register loaded serially, low bit first
		bank = 9'h1FC;
		for (int k = 0; k < 9; k++)
			z80_access(16'h6000, {7'b0000000, bank[k]}, 1'b1);
		for (int j = 0; j < 6; j++) begin
			rnd = $random(data_seed);
			za = {1'b1, rnd[14:0]};
			m68k_write({bank, za[14:1]}, 16'h0000, 1'b0, 1'b0);
			z80_access(za, rnd[23:16], 1'b1);
			z80_access(za, 8'h00, 1'b0);
			m68k_read({bank, za[14:1]}, 1'b0, 1'b0);
		end

		// 68000 and DMA request in the same cycle
		fork
			begin
				m68k_read(wr_addr[0], 1'b0, 1'b0);
				t_m68k = $time;
			end
			begin
				dma_read(wr_addr[1]);
				t_dma = $time;
			end
		join
		assert (t_m68k < t_dma) else begin
			$display("Order error: the DMA read finished before the 68000 read");
			flow_errors++;
		end

		repeat (4) @(negedge MCLK);
		$display("Errors: %0d value, %0d other", value_errors, flow_errors);
		if (value_errors == 0 && flow_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

//--- genesis_mbus.f
+incdir+testbench
verilog/mbus_pkg.sv
verilog/work_ram.sv
verilog/zbus_ctrl.sv
verilog/mbus_ctrl.sv
verilog/master_select.sv
verilog/genesis_mbus.sv
testbench/tb_genesis_mbus.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_genesis_mbus -f genesis_mbus.f --Mdir obj_dir

output=$(./obj_dir/Vtb_genesis_mbus)
echo "$output"

if echo "$output" | grep -qx "=== PASS ==="; then
	exit 0
fi
exit 1
